// File: verilog/byte_fifo_settings.svh
`ifndef BYTE_FIFO_SETTINGS_SVH
`define BYTE_FIFO_SETTINGS_SVH

// width of a word on the write side
`define FIFO_WORD_W 32

// width of a byte on the read side
`define FIFO_BYTE_W 8

// capacity in words, as log2
// 4 gives 16 words and 64 bytes
`define FIFO_DEPTH_LOG2 4

`endif

// File: verilog/byte_fifo_pkg.sv
package byte_fifo_pkg;

`include "byte_fifo_settings.svh"

   // bytes held by one word
   localparam int LANES = `FIFO_WORD_W / `FIFO_BYTE_W;

   // byte address into the whole storage
   localparam int BADDR_W = `FIFO_DEPTH_LOG2 + $clog2(LANES);

   // pointers carry one extra wrap bit
   localparam int WPTR_W = `FIFO_DEPTH_LOG2 + 1;
   localparam int BPTR_W = BADDR_W + 1;

   // wide write into the RAM
   // addr is in byte space with the lane bits at zero
   typedef struct packed {
      logic                    en;
      logic [BADDR_W-1:0]      addr;
      logic [`FIFO_WORD_W-1:0] data;
   } ram_wr_t;

   // narrow read request, one byte
   typedef struct packed {
      logic               en;
      logic [BADDR_W-1:0] addr;
   } ram_rd_t;

endpackage

// File: verilog/ram_2p.sv
`timescale 1ns/10ps

module ram_2p #(
   parameter int DATA_W = 8,
   parameter int ADDR_W = 4
) (
   input  logic              clk_i,
   // write port
   input  logic              w_en_i,
   input  logic [ADDR_W-1:0] w_addr_i,
   input  logic [DATA_W-1:0] w_data_i,
   // read port
   input  logic              r_en_i,
   input  logic [ADDR_W-1:0] r_addr_i,
   output logic [DATA_W-1:0] r_data_o
);

   logic [DATA_W-1:0] mem [2**ADDR_W];

   always_ff @(posedge clk_i) begin
      if (w_en_i) begin
         mem[w_addr_i] <= w_data_i;
      end
   end

   // registered read, output holds while r_en_i is low
   always_ff @(posedge clk_i) begin
      if (r_en_i) begin
         r_data_o <= mem[r_addr_i];
      end
   end

endmodule

// File: verilog/ram_2p_asym.sv
`timescale 1ns/10ps

`include "byte_fifo_settings.svh"

module ram_2p_asym #(
   parameter int W_DATA_W = `FIFO_WORD_W,
   parameter int R_DATA_W = `FIFO_BYTE_W,
   parameter int ADDR_W   = byte_fifo_pkg::BADDR_W
) (
   input  logic                    clk_i,
   input  byte_fifo_pkg::ram_wr_t  wr_i,
   input  byte_fifo_pkg::ram_rd_t  rd_i,
   output logic [R_DATA_W-1:0]     r_data_o
);

   // number of narrow blocks and lane select width
   localparam int N = W_DATA_W / R_DATA_W;
   localparam int N_W = $clog2(N);

   // each block holds one lane of every word
   localparam int BLK_ADDR_W = ADDR_W - N_W;

   logic [BLK_ADDR_W-1:0] blk_w_addr;
   logic [BLK_ADDR_W-1:0] blk_r_addr;
   logic [N_W-1:0]        r_lane;
   logic [N_W-1:0]        r_lane_q;
   logic [R_DATA_W-1:0]   blk_rd [N];

   // word address is the byte address without the lane bits
   assign blk_w_addr = wr_i.addr[ADDR_W-1:N_W];
   assign blk_r_addr = rd_i.addr[ADDR_W-1:N_W];
   assign r_lane     = rd_i.addr[N_W-1:0];

   for (genvar i = 0; i < N; i++) begin : g_blk
      // all blocks written in parallel with lane i from slice i
      ram_2p #(
         .DATA_W (R_DATA_W),
         .ADDR_W (BLK_ADDR_W)
      ) u_blk (
         .clk_i    (clk_i),
         .w_en_i   (wr_i.en),
         .w_addr_i (blk_w_addr),
         .w_data_i (wr_i.data[i*R_DATA_W +: R_DATA_W]),
         .r_en_i   (rd_i.en),
         .r_addr_i (blk_r_addr),
         .r_data_o (blk_rd[i])
      );
   end

   // lane select follows the block read register by one cycle
   always_ff @(posedge clk_i) begin
      if (rd_i.en) begin
         r_lane_q <= r_lane;
      end
   end

   // read mux stays stable while no read is issued
   assign r_data_o = blk_rd[r_lane_q];

endmodule

// File: verilog/fifo_wr_stage.sv
`timescale 1ns/10ps

`include "byte_fifo_settings.svh"

module fifo_wr_stage (
   input  logic                                clk_i,
   input  logic                                rst_n_i,
   input  logic                                word_valid_i,
   input  logic [`FIFO_WORD_W-1:0]             word_i,
   input  logic                                full_i,
   output byte_fifo_pkg::ram_wr_t              wr_o,
   output logic [byte_fifo_pkg::WPTR_W-1:0]    wr_ptr_o,
   output logic                                overflow_o
);

   localparam int LANE_W = $clog2(byte_fifo_pkg::LANES);
   localparam int WPTR_W = byte_fifo_pkg::WPTR_W;

   logic [WPTR_W-1:0] wr_ptr_q;
   logic              wr_acc;
   logic              overflow_q;

   // writes while full are dropped
   assign wr_acc = word_valid_i & ~full_i;

   // byte address of the word, wrap bit dropped
   assign wr_o.en   = wr_acc;
   assign wr_o.addr = {wr_ptr_q[WPTR_W-2:0], {LANE_W{1'b0}}};
   assign wr_o.data = word_i;

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         wr_ptr_q <= '0;
      end else if (wr_acc) begin
         wr_ptr_q <= wr_ptr_q + 1'b1;
      end
   end

   // sticky until reset
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         overflow_q <= 1'b0;
      end else if (word_valid_i && full_i) begin
         overflow_q <= 1'b1;
      end
   end

   assign wr_ptr_o   = wr_ptr_q;
   assign overflow_o = overflow_q;

endmodule

// File: verilog/fifo_rd_stage.sv
`timescale 1ns/10ps

`include "byte_fifo_settings.svh"

module fifo_rd_stage (
   input  logic                                clk_i,
   input  logic                                rst_n_i,
   input  logic                                byte_rd_i,
   input  logic [byte_fifo_pkg::WPTR_W-1:0]    wr_ptr_i,
   input  logic [`FIFO_BYTE_W-1:0]             rd_data_i,
   output byte_fifo_pkg::ram_rd_t              rd_o,
   output logic                                empty_o,
   output logic                                full_o,
   output logic [`FIFO_BYTE_W-1:0]             byte_o,
   output logic                                byte_valid_o
);

   localparam int BPTR_W  = byte_fifo_pkg::BPTR_W;
   localparam int BADDR_W = byte_fifo_pkg::BADDR_W;
   localparam int LANES   = byte_fifo_pkg::LANES;
   localparam int LANE_W  = BPTR_W - byte_fifo_pkg::WPTR_W;

   // full once fewer than one word of space is left
   localparam int FULL_AT = (2**BADDR_W) - LANES;

   logic [BPTR_W-1:0] rd_ptr_q;
   logic [BPTR_W-1:0] wr_bptr;
   logic [BPTR_W-1:0] fill;
   logic              empty;
   logic              rd_acc;
   logic              valid_q;

   // write pointer scaled into byte space
   assign wr_bptr = {wr_ptr_i, {LANE_W{1'b0}}};

   // wraps modulo 2**BPTR_W, the extra bit keeps full apart from empty
   assign fill = wr_bptr - rd_ptr_q;

   assign empty   = (fill == '0);
   assign empty_o = empty;
   assign full_o  = (fill > BPTR_W'(FULL_AT));

   // reads while empty are ignored
   assign rd_acc = byte_rd_i & ~empty;

   assign rd_o.en   = rd_acc;
   assign rd_o.addr = rd_ptr_q[BADDR_W-1:0];

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         rd_ptr_q <= '0;
      end else if (rd_acc) begin
         rd_ptr_q <= rd_ptr_q + 1'b1;
      end
   end

   // valid tracks the RAM read register, one cycle behind rd_acc
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         valid_q <= 1'b0;
      end else begin
         valid_q <= rd_acc;
      end
   end

   assign byte_valid_o = valid_q;

   // the RAM read register acts as the byte output register.
   // it only loads on an accepted read, so byte_o holds in between
   assign byte_o = rd_data_i;

endmodule

// File: verilog/word_to_byte_fifo.sv
`timescale 1ns/10ps

`include "byte_fifo_settings.svh"

module word_to_byte_fifo (
   input  logic                    clk_i,
   input  logic                    rst_n_i,
   // word side
   input  logic                    word_valid_i,
   input  logic [`FIFO_WORD_W-1:0] word_i,
   // byte side
   input  logic                    byte_rd_i,
   output logic [`FIFO_BYTE_W-1:0] byte_o,
   output logic                    byte_valid_o,
   // levels
   output logic                    empty_o,
   output logic                    full_o,
   output logic                    overflow_o
);

   byte_fifo_pkg::ram_wr_t              wr_port;
   byte_fifo_pkg::ram_rd_t              rd_port;
   logic [byte_fifo_pkg::WPTR_W-1:0]    wr_ptr;
   logic [`FIFO_BYTE_W-1:0]             rd_data;
   logic                                full;

   // word pointer and overflow
   fifo_wr_stage u_wr_stage (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .word_valid_i (word_valid_i),
      .word_i       (word_i),
      .full_i       (full),
      .wr_o         (wr_port),
      .wr_ptr_o     (wr_ptr),
      .overflow_o   (overflow_o)
   );

   // storage, wide in and narrow out
   ram_2p_asym #(
      .W_DATA_W (`FIFO_WORD_W),
      .R_DATA_W (`FIFO_BYTE_W),
      .ADDR_W   (byte_fifo_pkg::BADDR_W)
   ) u_ram (
      .clk_i    (clk_i),
      .wr_i     (wr_port),
      .rd_i     (rd_port),
      .r_data_o (rd_data)
   );

   // byte pointer, levels and output
   fifo_rd_stage u_rd_stage (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .byte_rd_i    (byte_rd_i),
      .wr_ptr_i     (wr_ptr),
      .rd_data_i    (rd_data),
      .rd_o         (rd_port),
      .empty_o      (empty_o),
      .full_o       (full),
      .byte_o       (byte_o),
      .byte_valid_o (byte_valid_o)
   );

   assign full_o = full;

endmodule

// File: verif/word_to_byte_fifo_asserts.sv
`timescale 1ns/10ps

module word_to_byte_fifo_asserts (
   input logic clk_i,
   input logic rst_n_i,
   input logic byte_rd_i,
   input logic byte_valid_o,
   input logic empty_o,
   input logic full_o,
   input logic overflow_o
);

   // read by the testbench at the end of the run
   int unsigned fail_count = 0;

   a_levels_exclusive : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      !(empty_o && full_o))
   else begin
      $error("empty_o and full_o are high together");
      fail_count++;
   end

   // one cycle of RAM read latency, both directions
   a_valid_after_read : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      byte_valid_o |-> $past(byte_rd_i && !empty_o))
   else begin
      $error("byte_valid_o high without an accepted read one cycle before");
      fail_count++;
   end

   a_read_gives_valid : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (byte_rd_i && !empty_o) |=> byte_valid_o)
   else begin
      $error("accepted read gave no byte_valid_o one cycle later");
      fail_count++;
   end

   a_overflow_sticky : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      $past(overflow_o) |-> overflow_o)
   else begin
      $error("overflow_o fell without reset");
      fail_count++;
   end

endmodule

bind word_to_byte_fifo word_to_byte_fifo_asserts u_asserts (
   .clk_i        (clk_i),
   .rst_n_i      (rst_n_i),
   .byte_rd_i    (byte_rd_i),
   .byte_valid_o (byte_valid_o),
   .empty_o      (empty_o),
   .full_o       (full_o),
   .overflow_o   (overflow_o)
);

// File: verif/word_to_byte_fifo_tb.sv
`timescale 1ns/10ps

`include "byte_fifo_settings.svh"

module word_to_byte_fifo_tb;

   localparam int LANES       = byte_fifo_pkg::LANES;
   localparam int BYTE_W      = `FIFO_BYTE_W;
   localparam int CAP_BYTES   = (1 << `FIFO_DEPTH_LOG2) * LANES;
   localparam int FULL_LEVEL  = CAP_BYTES - LANES;
   localparam int RAND_CYCLES = 2000;
   // resets, empty read, byte order, streaming, random plus drain, levels, overflow
   localparam int TEST_CYCLES = 2 * 8 + 2 + 21 + 21 + (RAND_CYCLES + 65) + 81 + 82;
   localparam int TIMEOUT_CYCLES = TEST_CYCLES + 200;

   logic                    clk_i;
   logic                    rst_n_i;
   logic                    word_valid_i;
   logic [`FIFO_WORD_W-1:0] word_i;
   logic                    byte_rd_i;
   logic [BYTE_W-1:0]       byte_o;
   logic                    byte_valid_o;
   logic                    empty_o;
   logic                    full_o;
   logic                    overflow_o;

   // byte-queue model
   logic [BYTE_W-1:0] model_q [$];
   logic [BYTE_W-1:0] pend_byte;
   logic              pend_valid;
   logic              ovf_exp;

   logic [31:0] lfsr_state;
   int          errors;
   int          err_mark;
   int          tests_run;
   int          tests_failed;
   int          valid_seen;
   int          mark;
   int          cycle_count;

   word_to_byte_fifo dut (.*);

   initial begin
      clk_i = 1'b0;
      forever begin
         #4 clk_i = ~clk_i;
      end
   end

   always @(posedge clk_i) begin
      cycle_count++;
      if (cycle_count > TIMEOUT_CYCLES) begin
         $display("run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("TESTBENCH FAILED");
         $finish;
      end
   end

   // galois form of x^32 + x^22 + x^2 + x + 1
   function automatic logic rand_bit();
      logic b;
      b = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (b) begin
         lfsr_state = lfsr_state ^ 32'h8020_0003;
      end
      return b;
   endfunction

   function automatic logic [`FIFO_WORD_W-1:0] rand_word();
      logic [`FIFO_WORD_W-1:0] w;
      for (int i = 0; i < `FIFO_WORD_W; i++) begin
         w[i] = rand_bit();
      end
      return w;
   endfunction

   task automatic check_byte();
      if (byte_valid_o) begin
         valid_seen++;
      end
      assert (byte_valid_o == pend_valid) else begin
         $display("FAILED at %0t: byte_valid_o %b, expected %b", $time, byte_valid_o,
                  pend_valid);
         errors++;
      end
      if (pend_valid) begin
         assert (byte_o == pend_byte) else begin
            $display("FAILED at %0t: byte_o %h, expected %h", $time, byte_o, pend_byte);
            errors++;
         end
      end
   endtask

   task automatic check_levels();
      assert (empty_o == (model_q.size() == 0) && full_o == (model_q.size() > FULL_LEVEL))
      else begin
         $display("FAILED at %0t: empty_o %b full_o %b with %0d bytes held", $time,
                  empty_o, full_o, model_q.size());
         errors++;
      end
      assert (overflow_o == ovf_exp) else begin
         $display("FAILED at %0t: overflow_o %b, expected %b", $time, overflow_o, ovf_exp);
         errors++;
      end
   endtask

   // drive one clock then advance the model and compare
   task automatic cycle(input logic wv, input logic [`FIFO_WORD_W-1:0] w, input logic rd);
      logic wr_ok;
      logic rd_ok;
      wr_ok = wv && (model_q.size() <= FULL_LEVEL);
      rd_ok = rd && (model_q.size() != 0);
      word_valid_i = wv;
      word_i       = w;
      byte_rd_i    = rd;
      @(posedge clk_i);
      #1;
      // a read accepted at this edge shows on byte_o right after it
      pend_valid = rd_ok;
      if (rd_ok) begin
         pend_byte = model_q.pop_front();
      end
      check_byte();
      if (wr_ok) begin
         for (int i = 0; i < LANES; i++) begin
            model_q.push_back(w[i*BYTE_W +: BYTE_W]);
         end
      end else if (wv) begin
         ovf_exp = 1'b1;
      end
      check_levels();
   endtask

   task automatic drain();
      while (model_q.size() != 0) begin
         cycle(1'b0, '0, 1'b1);
      end
      cycle(1'b0, '0, 1'b0);
   endtask

   task automatic reset_dut();
      rst_n_i      = 1'b0;
      word_valid_i = 1'b0;
      byte_rd_i    = 1'b0;
      repeat (8) @(posedge clk_i);
      #1;
      rst_n_i = 1'b1;
      model_q.delete();
      pend_valid = 1'b0;
      ovf_exp    = 1'b0;
   endtask

   task automatic report(input string name);
      tests_run++;
      if (errors == err_mark) begin
         $display("test %-14s ok", name);
      end else begin
         tests_failed++;
         $display("test %-14s %0d errors", name, errors - err_mark);
      end
      err_mark = errors;
   endtask

   initial begin
      rst_n_i      = 1'b0;
      word_valid_i = 1'b0;
      word_i       = '0;
      byte_rd_i    = 1'b0;
      lfsr_state   = 32'hb87d;
      errors       = 0;
      err_mark     = 0;
      tests_run    = 0;
      tests_failed = 0;
      valid_seen   = 0;
      cycle_count  = 0;
      reset_dut();

      assert (empty_o && !full_o && !overflow_o && !byte_valid_o) else begin
         $display("FAILED at %0t: levels wrong after reset", $time);
         errors++;
      end
      mark = valid_seen;
      cycle(1'b0, '0, 1'b1);
      cycle(1'b0, '0, 1'b0);
      assert (valid_seen == mark) else begin
         $display("FAILED at %0t: read while empty gave a byte", $time);
         errors++;
      end
      report("reset");

      for (int i = 0; i < 4; i++) begin
         cycle(1'b1, rand_word(), 1'b0);
      end
      drain();
      report("byte order");

      for (int i = 0; i < 4; i++) begin
         cycle(1'b1, rand_word(), 1'b0);
      end
      mark = valid_seen;
      drain();
      assert (valid_seen - mark == 16) else begin
         $display("FAILED at %0t: %0d bytes streamed, expected 16", $time, valid_seen - mark);
         errors++;
      end
      report("streaming");

      for (int i = 0; i < RAND_CYCLES; i++) begin
         cycle(rand_bit(), rand_word(), rand_bit());
      end
      drain();
      report("random");

      for (int i = 0; i < CAP_BYTES / LANES; i++) begin
         cycle(1'b1, rand_word(), 1'b0);
      end
      drain();
      report("levels");

      reset_dut();
      for (int i = 0; i <= CAP_BYTES / LANES; i++) begin
         cycle(1'b1, rand_word(), 1'b0);
         if (i == CAP_BYTES / LANES - 1) begin
            assert (full_o) else begin
               $display("FAILED at %0t: full_o low after the last word that fits", $time);
               errors++;
            end
         end
      end
      assert (overflow_o) else begin
         $display("FAILED at %0t: overflow_o low after a dropped word", $time);
         errors++;
      end
      mark = valid_seen;
      drain();
      assert (valid_seen - mark == CAP_BYTES) else begin
         $display("FAILED at %0t: drained %0d bytes, expected %0d", $time,
                  valid_seen - mark, CAP_BYTES);
         errors++;
      end
      report("overflow");

      $display("tests %0d, failed %0d, check errors %0d, assertion failures %0d",
               tests_run, tests_failed, errors, dut.u_asserts.fail_count);
      if (errors == 0 && dut.u_asserts.fail_count == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

// File: sim.f
+incdir+verilog
verilog/byte_fifo_pkg.sv
verilog/ram_2p.sv
verilog/ram_2p_asym.sv
verilog/fifo_wr_stage.sv
verilog/fifo_rd_stage.sv
verilog/word_to_byte_fifo.sv
verif/word_to_byte_fifo_asserts.sv
verif/word_to_byte_fifo_tb.sv
